// ==== lc3b_exec_core.f ====
+incdir+verilog
verilog/lc3b_types.sv
verilog/control_rom.sv
verilog/regfile.sv
verilog/alu.sv
verilog/lc3b_exec_core.sv
verif/lc3b_exec_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the LC-3b execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lc3b_exec_core.f \
    --top-module lc3b_exec_core_tb -Mdir obj_dir -o lc3b_exec_core_sim \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/lc3b_exec_core_sim)"
echo "$out"

grep -qx "sim passed" <<< "$out" && exit 0 || exit 1

// ==== verif/lc3b_exec_core_tb.sv ====
`include "lc3b_settings.svh"

module lc3b_exec_core_tb;

    import lc3b_types::*;

    localparam int issue_cycles = 600;
    localparam int reset_cycles = 16;
    localparam int max_cycles   = issue_cycles + reset_cycles + 20;

    logic       clk;
    logic       rst_n;
    logic       instr_valid;
    lc3b_word   instr;
    logic       result_valid;
    lc3b_result result;

    integer     seed;
    int         cycles = 0;
    int         mismatch_errors = 0;
    int         order_errors = 0;
    int         timeout_errors = 0;

    lc3b_word   model_regs [`LC3B_NUM_REGS];
    lc3b_nzp    model_cc;
    lc3b_result expected_q [$];
    int         issue_q [$];    // posedge count at issue

    lc3b_exec_core DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // period 8
    end

    // three in four picks land in r0..r3 to make dependencies common
    function automatic lc3b_reg pick_reg(input logic [3:0] bits);
        if (bits[3:2] != 2'b11)
            return {1'b0, bits[1:0]};
        else
            return bits[2:0];
    endfunction

    function automatic lc3b_word build_instr(input logic [31:0] rnd);
        logic [3:0] mix;
        logic [3:0] op;
        mix = rnd[31:28];
        if (mix < 4'd12) begin
            case (mix[1:0])
                2'd0:    op = op_add;
                2'd1:    op = op_and;
                2'd2:    op = op_not;
                default: op = op_shf;
            endcase
        end else begin
            op = rnd[27:24];    // any opcode, mostly unsupported
        end
        return {op, pick_reg(rnd[23:20]), pick_reg(rnd[19:16]), rnd[11:9],
                pick_reg(rnd[15:12])};
    endfunction

    // reference model applied in issue order
    task automatic apply_model(input lc3b_word w);
        lc3b_word   a;
        lc3b_word   b;
        lc3b_word   val;
        lc3b_result exp_res;
        int         shamt;
        logic       supported;
        a = model_regs[w[8:6]];
        // imm5 is two's complement, so a set bit 4 takes 32 off
        b = w[5] ? lc3b_word'(w[4:0]) - (w[4] ? 16'd32 : 16'd0) : model_regs[w[2:0]];
        shamt = {28'd0, w[3:0]};
        supported = 1'b1;
        val = '0;
        case (lc3b_opcode'(w[15:12]))
            op_add: val = a + b;
            op_and: val = a & b;
            op_not: val = ~a;
            op_shf: begin
                if (!w[4]) begin
                    val = a << shamt;
                end else if (!w[5]) begin
                    val = a >> shamt;
                end else begin
                    val = a;
                    repeat (shamt)
                        val = {val[`LC3B_WORD_BITS-1], val[`LC3B_WORD_BITS-1:1]};
                end
            end
            default: supported = 1'b0;    // no architectural effect
        endcase
        if (supported) begin
            model_regs[w[11:9]] = val;
            if (val[`LC3B_WORD_BITS-1])
                model_cc = 3'b100;    // negative
            else if (val == '0)
                model_cc = 3'b010;
            else
                model_cc = 3'b001;
            exp_res.dest = w[11:9];
            exp_res.data = val;
            exp_res.cc   = model_cc;
            expected_q.push_back(exp_res);
            issue_q.push_back(cycles);
        end
    endtask

    task automatic compare_value(input string field, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            mismatch_errors = mismatch_errors + 1;
            $display("Error: time %0t: %s mismatch, got %0h expected %0h",
                     $time, field, got, expected);
        end
    endtask

    task automatic collect_result();
        lc3b_result exp_res;
        int         issued;
        if (result_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                order_errors = order_errors + 1;
                $display("unexpected result at time %0t with no instruction outstanding",
                         $time);
            end else begin
                exp_res = expected_q.pop_front();
                issued  = issue_q.pop_front();
                compare_value("dest", 32'(result.dest), 32'(exp_res.dest));
                compare_value("data", 32'(result.data), 32'(exp_res.data));
                compare_value("cc", 32'(result.cc), 32'(exp_res.cc));
                compare_value("latency", cycles - issued, 32'd2);
            end
        end
    endtask

    task automatic issue_random();
        logic [31:0] rnd_v;
        logic [31:0] rnd;
        rnd_v = $random(seed);
        rnd   = $random(seed);
        instr       = build_instr(rnd);
        instr_valid = (rnd_v % 32'd100) < 32'd70;    // about 70 percent
        if (instr_valid)
            apply_model(instr);
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatch, %0d missing or extra, %0d timeout",
                 mismatch_errors, order_errors, timeout_errors);
    endtask

    initial begin
        seed        = 32'h91e5_63e5;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        model_cc    = `LC3B_RESET_CC;
        for (int i = 0; i < `LC3B_NUM_REGS; i++)
            model_regs[i] = '0;

        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < issue_cycles; i++) begin
            @(negedge clk);
            collect_result();
            issue_random();
        end

        repeat (3) begin    // drain the pipe
            @(negedge clk);
            collect_result();
            instr_valid = 1'b0;
        end

        if (expected_q.size() != 0) begin
            order_errors = order_errors + expected_q.size();
            $display("missing results: %0d issued instructions were never reported",
                     expected_q.size());
        end
        print_counts();
        if (mismatch_errors + order_errors + timeout_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            timeout_errors = timeout_errors + 1;
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            print_counts();
            $display("sim failed");
            $finish;
        end
    end

endmodule : lc3b_exec_core_tb

// ==== verilog/lc3b_exec_core.sv ====
`include "lc3b_settings.svh"

module lc3b_exec_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  lc3b_types::lc3b_word   instr,
    output logic                   result_valid,
    output lc3b_types::lc3b_result result
);

    import lc3b_types::*;

    lc3b_control_word ctrl;
    lc3b_reg          sr1_idx;
    lc3b_reg          sr2_idx;
    lc3b_reg          dest_idx;
    lc3b_word         rf_a;
    lc3b_word         rf_b;
    lc3b_word         opnd_a;
    lc3b_word         sr2_val;
    lc3b_word         imm5_sext;
    lc3b_word         imm4_zext;
    lc3b_ex_stage     ex_d;
    lc3b_ex_stage     ex_q;
    lc3b_word         alu_f;
    logic             ex_writes;
    logic             ex_retire;
    lc3b_nzp          nzp_new;
    lc3b_nzp          cc_q;
    lc3b_nzp          cc_next;

    assign sr1_idx  = instr[8:6];
    assign sr2_idx  = instr[2:0];
    assign dest_idx = instr[11:9];

    assign imm5_sext = {{(`LC3B_WORD_BITS-5){instr[4]}}, instr[4:0]};
    assign imm4_zext = {{(`LC3B_WORD_BITS-4){1'b0}}, instr[3:0]};

    control_rom u_control_rom (
        .ir_in       (instr),
        .control_out (ctrl)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (ex_writes),
        .dest  (ex_q.dest),
        .in    (alu_f),
        .src_a (sr1_idx),
        .src_b (sr2_idx),
        .reg_a (rf_a),
        .reg_b (rf_b)
    );

    // EX result bypasses the register file write of the same cycle
    assign ex_writes = ex_q.valid && ex_q.control.regfile_load;
    assign opnd_a    = (ex_writes && ex_q.dest == sr1_idx) ? alu_f : rf_a;
    assign sr2_val   = (ex_writes && ex_q.dest == sr2_idx) ? alu_f : rf_b;

    always_comb begin
        ex_d.valid   = instr_valid;
        ex_d.control = ctrl;
        ex_d.src_a   = opnd_a;
        ex_d.dest    = dest_idx;
        case (ctrl.alu_mux_sel)
            alu_mux_imm5: ex_d.src_b = imm5_sext;
            alu_mux_imm4: ex_d.src_b = imm4_zext;
            default:      ex_d.src_b = sr2_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_d;    // loads every cycle since nothing stalls
        end
    end

    alu u_alu (
        .aluop (ex_q.control.alu_op),
        .a     (ex_q.src_a),
        .b     (ex_q.src_b),
        .f     (alu_f)
    );

    // nzp from the written value
    assign nzp_new = {alu_f[`LC3B_WORD_BITS-1], (alu_f == '0),
                      !alu_f[`LC3B_WORD_BITS-1] && (alu_f != '0)};

    assign cc_next   = (ex_q.valid && ex_q.control.cc_load) ? nzp_new : cc_q;
    assign ex_retire = ex_q.valid && (ex_q.control.regfile_load || ex_q.control.cc_load);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc_q <= `LC3B_RESET_CC;
        end else begin
            cc_q <= cc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= ex_retire;    // unsupported ops never report
            if (ex_retire) begin
                result.dest <= ex_q.dest;
                result.data <= alu_f;
                result.cc   <= cc_next;
            end
        end
    end

    // two strobes back to back are the only source of two results in a row
    assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && $past(result_valid) |-> $past(instr_valid, 2) && $past(instr_valid, 3))
        else $error("lc3b_exec_core: result_valid held without back-to-back issue");

    assert property (@(posedge clk) disable iff (!rst_n) $onehot(cc_q))
        else $error("lc3b_exec_core: cc not one-hot");

endmodule : lc3b_exec_core

// ==== verilog/alu.sv ====
module alu (
    input  lc3b_types::lc3b_alu_op aluop,
    input  lc3b_types::lc3b_word   a,
    input  lc3b_types::lc3b_word   b,
    output lc3b_types::lc3b_word   f
);

    import lc3b_types::*;

    logic [3:0] shamt;

    assign shamt = b[3:0];    // imm4 from the decode mux

    always_comb begin
        case (aluop)
            alu_add: begin
                f = a + b;
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a;
            end
            alu_sll: begin
                f = a << shamt;
            end
            alu_srl: begin
                f = a >> shamt;
            end
            alu_sra: begin
                f = lc3b_word'($signed(a) >>> shamt);    // sign fill
            end
            default: begin
                f = a;    // alu_pass
            end
        endcase
    end

endmodule : alu

// ==== verilog/regfile.sv ====
`include "lc3b_settings.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    import lc3b_types::*;

    lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // same-cycle write is not visible here
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule : regfile

// ==== verilog/control_rom.sv ====
module control_rom (
    input  lc3b_types::lc3b_word         ir_in,
    output lc3b_types::lc3b_control_word control_out
);

    import lc3b_types::*;

    lc3b_opcode opcode;

    assign opcode = lc3b_opcode'(ir_in[15:12]);

    always_comb begin
        // everything off unless the opcode says otherwise
        control_out.alu_mux_sel  = alu_mux_sr2;
        control_out.alu_op       = alu_pass;
        control_out.cc_load      = 1'b0;
        control_out.regfile_load = 1'b0;

        case (opcode)
            op_add: begin
                if (ir_in[5] == 1'b0)
                    control_out.alu_mux_sel = alu_mux_sr2;
                else
                    control_out.alu_mux_sel = alu_mux_imm5;
                control_out.alu_op       = alu_add;
                control_out.cc_load      = 1'b1;
                control_out.regfile_load = 1'b1;
            end

            op_and: begin
                if (ir_in[5] == 1'b0)
                    control_out.alu_mux_sel = alu_mux_sr2;
                else
                    control_out.alu_mux_sel = alu_mux_imm5;
                control_out.alu_op       = alu_and;
                control_out.cc_load      = 1'b1;
                control_out.regfile_load = 1'b1;
            end

            op_not: begin
                control_out.alu_op       = alu_not;    // operand b unused
                control_out.cc_load      = 1'b1;
                control_out.regfile_load = 1'b1;
            end

            op_shf: begin
                control_out.alu_mux_sel = alu_mux_imm4;    // shift amount
                if (ir_in[4] == 1'b0)
                    control_out.alu_op = alu_sll;
                else if (ir_in[5] == 1'b0)
                    control_out.alu_op = alu_srl;
                else
                    control_out.alu_op = alu_sra;
                control_out.cc_load      = 1'b1;
                control_out.regfile_load = 1'b1;
            end

            default: begin
                // branches, memory ops and trap do nothing in this slice
                control_out = '0;
            end
        endcase

        // decoded ops always write and set cc together
        assert (control_out.regfile_load == control_out.cc_load)
            else $error("control_rom: regfile_load and cc_load disagree");
    end

endmodule : control_rom

// ==== verilog/lc3b_types.sv ====
`include "lc3b_settings.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_BITS-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;    // n z p

    // LC-3b opcode field in ir[15:12]
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_pass = 3'd0,    // zero control word lands here
        alu_add  = 3'd1,
        alu_and  = 3'd2,
        alu_not  = 3'd3,
        alu_sll  = 3'd4,
        alu_srl  = 3'd5,
        alu_sra  = 3'd6
    } lc3b_alu_op;

    typedef enum logic [1:0] {
        alu_mux_sr2  = 2'd0,
        alu_mux_imm5 = 2'd1,
        alu_mux_imm4 = 2'd2
    } lc3b_alu_mux_sel;

    typedef struct packed {
        lc3b_alu_mux_sel alu_mux_sel;
        lc3b_alu_op      alu_op;
        logic            cc_load;
        logic            regfile_load;
    } lc3b_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_control_word control;
        lc3b_word         src_a;
        lc3b_word         src_b;    // immediate already muxed in
        lc3b_reg          dest;
    } lc3b_ex_stage;

    typedef struct packed {
        lc3b_reg  dest;
        lc3b_word data;
        lc3b_nzp  cc;
    } lc3b_result;

endpackage : lc3b_types

// ==== verilog/lc3b_settings.svh ====
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// data path and instruction width
`define LC3B_WORD_BITS 16

// architectural register count, r0 to r7
`define LC3B_NUM_REGS 8

// nzp after reset has only z set
`define LC3B_RESET_CC 3'b010

`endif
